// ==== logic/nocPkg.sv ====
package nocPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Flit format
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [15:0] flitT;   // Id in [15:13], payload in [12:0]
  typedef logic [2:0]  flitIdT;
  typedef logic [11:0] lengthT; // Header payload [11:0], flits incl. header

  localparam flitIdT HEADER_ID = 3'd1;
  localparam flitIdT BODY_ID   = 3'd2;
  localparam flitIdT TAIL_ID   = 3'd3; // Carried only

  ////////////////////////////////////////////////////////////////////////////
  // Ports and arbitration
  ////////////////////////////////////////////////////////////////////////////

  typedef logic [2:0] portT; // L 0, N 1, E 2, W 3, S 4

  localparam int NUM_PORTS = 5;

  // Grant states follow port order, state value is port plus one
  typedef enum logic [2:0]
  {
    IDLE    = 3'd0,
    GRANT_L = 3'd1,
    GRANT_N = 3'd2,
    GRANT_E = 3'd3,
    GRANT_W = 3'd4,
    GRANT_S = 3'd5
  } arbStateT;

endpackage

// ==== logic/inputBuffer.sv ====
`timescale 1ns/1ns

module inputBuffer
#(
  parameter int BUFFER_DEPTH = 8
)
(
  input  logic         clk,
  input  logic         rst,
  input  nocPkg::flitT writeFlit,
  input  logic         write,
  input  logic         pop,
  output nocPkg::flitT headFlit,
  output logic         notEmpty,
  output logic         full
);

  localparam int ADDR_WIDTH = $clog2(BUFFER_DEPTH);

  nocPkg::flitT mem [BUFFER_DEPTH];

  // Extra top bit tells a full buffer from an empty one
  logic [ADDR_WIDTH:0] wrPtr;
  logic [ADDR_WIDTH:0] rdPtr;
  logic                doWrite;
  logic                doPop;

  ////////////////////////////////////////////////////////////////////////////
  // Flags
  ////////////////////////////////////////////////////////////////////////////

  assign notEmpty = (wrPtr != rdPtr);
  assign full     = (wrPtr[ADDR_WIDTH] != rdPtr[ADDR_WIDTH]) &&
                    (wrPtr[ADDR_WIDTH-1:0] == rdPtr[ADDR_WIDTH-1:0]);

  assign doPop   = pop && notEmpty;
  assign doWrite = write && (!full || doPop); // Pop frees the slot

  assign headFlit = mem[rdPtr[ADDR_WIDTH-1:0]];

  ////////////////////////////////////////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    if (doWrite)
    begin
      mem[wrPtr[ADDR_WIDTH-1:0]] <= writeFlit;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
    end
    else
    begin
      if (doWrite)
      begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop)
      begin
        rdPtr <= rdPtr + 1'b1;
      end
    end
  end

endmodule

// ==== logic/grantTimer.sv ====
`timescale 1ns/1ns

module grantTimer
(
  input  logic           clk,
  input  logic           rst,
  input  logic           run,
  input  logic           headerPop,
  input  nocPkg::lengthT headerLength,
  output logic           timesUp
);

  nocPkg::lengthT quota;       // Stored per port
  nocPkg::lengthT sentCount;   // Pops so far in this grant
  nocPkg::lengthT newQuota;
  nocPkg::lengthT activeQuota;
  nocPkg::lengthT effCount;

  assign newQuota    = (headerLength == '0) ? 12'd1 : headerLength; // Zero acts as one
  assign activeQuota = headerPop ? newQuota : quota;
  assign effCount    = headerPop ? '0 : sentCount; // Header restarts the count

  // High on the last pop the quota allows
  assign timesUp = run && (effCount >= activeQuota - 12'd1);

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      quota     <= 12'd1;
      sentCount <= '0;
    end
    else
    begin
      if (headerPop)
      begin
        quota <= newQuota;
      end
      sentCount <= run ? effCount + 12'd1 : '0;
    end
  end

endmodule

// ==== logic/outputArbiter.sv ====
`timescale 1ns/1ns

module outputArbiter
(
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::flitT                 headFlit [nocPkg::NUM_PORTS],
  input  logic [nocPkg::NUM_PORTS-1:0] notEmpty,
  output logic [nocPkg::NUM_PORTS-1:0] pop,
  output nocPkg::flitT                 outFlit,
  output logic                         outValid,
  output nocPkg::portT                 outPort
);

  nocPkg::arbStateT state;
  nocPkg::arbStateT nextState;

  logic                         granted;
  logic                         grantDone; // Quota spent on the last pop
  logic                         popNow;
  nocPkg::portT                 grantPort;
  nocPkg::portT                 basePort;
  nocPkg::portT                 nextPort;
  nocPkg::flitT                 popFlit;
  nocPkg::lengthT               headerLength;
  logic                         isHeader;
  logic [nocPkg::NUM_PORTS-1:0] timesUp;

  assign granted   = (state != nocPkg::IDLE);
  assign grantPort = granted ? nocPkg::portT'(state - 3'd1) : '0;
  assign popFlit   = headFlit[grantPort];
  assign popNow    = granted && notEmpty[grantPort] && !grantDone;

  assign isHeader     = (nocPkg::flitIdT'(popFlit[15:13]) == nocPkg::HEADER_ID);
  assign headerLength = popFlit[11:0];

  ////////////////////////////////////////////////////////////////////////////
  // Per-port pop and quota timers
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < nocPkg::NUM_PORTS; p++)
  begin : gPort
    assign pop[p] = popNow && (grantPort == p);

    grantTimer timer
    (
      .clk          (clk),
      .rst          (rst),
      .run          (pop[p]),
      .headerPop    (pop[p] && isHeader),
      .headerLength (headerLength),
      .timesUp      (timesUp[p])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Rotating grant
  ////////////////////////////////////////////////////////////////////////////

  // From IDLE start the search just after South, so Local comes first
  assign basePort = granted ? grantPort : nocPkg::portT'(nocPkg::NUM_PORTS - 1);

  always_comb
  begin
    int idx;
    nextPort = '0;
    for (int i = nocPkg::NUM_PORTS; i >= 1; i--) // Nearest requester wins
    begin
      idx = (int'(basePort) + i) % nocPkg::NUM_PORTS;
      if (notEmpty[idx])
      begin
        nextPort = nocPkg::portT'(idx);
      end
    end
  end

  always_comb
  begin
    nextState = state;
    if (!popNow) // Decision cycle, no pop
    begin
      nextState = (|notEmpty) ? nocPkg::arbStateT'(nextPort + 3'd1) : nocPkg::IDLE;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= nocPkg::IDLE;
      grantDone <= 1'b0;
      outValid  <= 1'b0;
    end
    else
    begin
      state     <= nextState;
      grantDone <= popNow && timesUp[grantPort];
      outValid  <= popNow;
    end
  end

  // Output link payload
  always_ff @(posedge clk)
  begin
    if (popNow)
    begin
      outFlit <= popFlit;
      outPort <= grantPort;
    end
  end

endmodule

// ==== logic/routerOutputStage.sv ====
`timescale 1ns/1ns

module routerOutputStage
#(
  parameter int BUFFER_DEPTH = 8
)
(
  input  logic                         clk,
  input  logic                         rst,
  input  nocPkg::flitT                 inFlit [nocPkg::NUM_PORTS],
  input  logic [nocPkg::NUM_PORTS-1:0] inWrite,
  output logic [nocPkg::NUM_PORTS-1:0] bufferFull,
  output nocPkg::flitT                 outFlit,
  output logic                         outValid,
  output nocPkg::portT                 outPort
);

  nocPkg::flitT                 headFlit [nocPkg::NUM_PORTS];
  logic [nocPkg::NUM_PORTS-1:0] notEmpty;
  logic [nocPkg::NUM_PORTS-1:0] pop;

  ////////////////////////////////////////////////////////////////////////////
  // Input FIFOs, order L N E W S
  ////////////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < nocPkg::NUM_PORTS; p++)
  begin : gBuffer
    inputBuffer
    #(
      .BUFFER_DEPTH (BUFFER_DEPTH)
    )
    buffer
    (
      .clk       (clk),
      .rst       (rst),
      .writeFlit (inFlit[p]),
      .write     (inWrite[p]),
      .pop       (pop[p]),
      .headFlit  (headFlit[p]),
      .notEmpty  (notEmpty[p]),
      .full      (bufferFull[p])
    );
  end

  ////////////////////////////////////////////////////////////////////////////
  // Shared output link
  ////////////////////////////////////////////////////////////////////////////

  outputArbiter arbiter
  (
    .clk      (clk),
    .rst      (rst),
    .headFlit (headFlit),
    .notEmpty (notEmpty),
    .pop      (pop),
    .outFlit  (outFlit),
    .outValid (outValid),
    .outPort  (outPort)
  );

endmodule

// ==== testbench/routerOutputStage_asserts.sv ====
`timescale 1ns/1ns

module routerOutputStage_asserts
(
  input logic                         clk,
  input logic                         rst,
  input logic                         outValid,
  input nocPkg::portT                 outPort,
  input logic [nocPkg::NUM_PORTS-1:0] pop
);

  // Only real ports on the output link
  validPort: assert property (@(posedge clk) disable iff (rst)
    outValid |-> (outPort < nocPkg::portT'(nocPkg::NUM_PORTS)))
    else $error("outPort out of range while outValid is high");

  // One buffer popped at a time
  singlePop: assert property (@(posedge clk) disable iff (rst) $onehot0(pop))
    else $error("more than one pop strobe high");

  resetQuiet: assert property (@(posedge clk) rst |=> !outValid)
    else $error("outValid high in the cycle after reset");

endmodule

bind routerOutputStage routerOutputStage_asserts asserts
(
  .clk      (clk),
  .rst      (rst),
  .outValid (outValid),
  .outPort  (outPort),
  .pop      (pop)
);

// ==== testbench/routerOutputStageTb.sv ====
`timescale 1ns/1ns

module routerOutputStageTb;

  localparam int NUM_PHASES = 5;
  localparam int DEPTH      = 8;

  // Phase rows over ports L N E W S
  localparam int COUNT_TAB [NUM_PHASES][nocPkg::NUM_PORTS] =
    '{'{4, 3, 5, 2, 6}, '{8, 4, 0, 6, 0}, '{0, 0, 7, 0, 0}, '{8, 0, 0, 0, 8}, '{0, 1, 0, 2, 0}};
  localparam int LENGTH_TAB [NUM_PHASES][nocPkg::NUM_PORTS] =
    '{'{4, 3, 5, 2, 6}, '{3, 4, 0, 2, 0}, '{0, 0, 7, 0, 0}, '{8, 0, 0, 0, 8}, '{0, 0, 0, 0, 0}};
  localparam int TAG_TAB [NUM_PHASES][nocPkg::NUM_PORTS] =
    '{'{17, 18, 19, 20, 21}, '{33, 34, 35, 36, 37}, '{49, 50, 51, 52, 53},
      '{65, 66, 67, 68, 69}, '{81, 82, 83, 84, 85}};

  logic                         clk;
  logic                         rst;
  nocPkg::flitT                 inFlit [nocPkg::NUM_PORTS];
  logic [nocPkg::NUM_PORTS-1:0] inWrite;
  logic [nocPkg::NUM_PORTS-1:0] bufferFull;
  nocPkg::flitT                 outFlit;
  logic                         outValid;
  nocPkg::portT                 outPort;

  nocPkg::flitT portQ [nocPkg::NUM_PORTS][$]; // Written and not yet seen
  nocPkg::portT expPorts[$];                  // Grant order model
  bit           expEnd[$];                    // Last flit of a turn
  nocPkg::flitT phaseFlits [nocPkg::NUM_PORTS][DEPTH];
  int           quotaModel [nocPkg::NUM_PORTS];
  int           writeCnt [nocPkg::NUM_PORTS];
  int           popCnt [nocPkg::NUM_PORTS];
  bit           prevEnd;
  logic [31:0]  lfsr;
  int           flitErrors;
  int           portErrors;
  int           otherErrors;

  routerOutputStage #(.BUFFER_DEPTH(DEPTH)) DUT
  (
    .clk        (clk),
    .rst        (rst),
    .inFlit     (inFlit),
    .inWrite    (inWrite),
    .bufferFull (bufferFull),
    .outFlit    (outFlit),
    .outValid   (outValid),
    .outPort    (outPort)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and model helpers
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] nextLfsr(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  task automatic drawBits(input int n, output logic [12:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      bits = {bits[11:0], lfsr[0]};
      lfsr = nextLfsr(lfsr);
    end
  endtask

  task automatic buildPhase(input int ph);
    logic [12:0] body;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      for (int k = 0; k < COUNT_TAB[ph][p]; k++)
      begin
        if (k == 0)
          phaseFlits[p][k] = {nocPkg::HEADER_ID, 1'b0, nocPkg::lengthT'(LENGTH_TAB[ph][p])};
        else if (k == COUNT_TAB[ph][p] - 1)
          phaseFlits[p][k] = {nocPkg::TAIL_ID, 13'(TAG_TAB[ph][p])};
        else
        begin
          drawBits(13, body);
          phaseFlits[p][k] = {nocPkg::BODY_ID, body};
        end
        portQ[p].push_back(phaseFlits[p][k]);
      end
    end
  endtask

  // Rotating turns limited by each port's stored quota
  task automatic planTurns(input int ph);
    int left [nocPkg::NUM_PORTS];
    int pos [nocPkg::NUM_PORTS];
    int cur;
    int next;
    int cnt;
    bit done;
    nocPkg::flitT f;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      left[p] = COUNT_TAB[ph][p];
      pos[p]  = 0;
    end
    cur = nocPkg::NUM_PORTS - 1; // Search from IDLE starts at Local
    forever
    begin
      next = -1;
      for (int i = 1; i <= nocPkg::NUM_PORTS && next < 0; i++)
        if (left[(cur + i) % nocPkg::NUM_PORTS] > 0)
          next = (cur + i) % nocPkg::NUM_PORTS;
      if (next < 0)
        break;
      cur  = next;
      cnt  = 0;
      done = 1'b0;
      while (!done)
      begin
        f = phaseFlits[cur][pos[cur]];
        if (f[15:13] == nocPkg::HEADER_ID)
        begin
          quotaModel[cur] = (f[11:0] == 12'd0) ? 1 : int'(f[11:0]);
          cnt = 0;
        end
        pos[cur]++;
        left[cur]--;
        cnt++;
        done = (cnt >= quotaModel[cur]) || (left[cur] == 0);
        expPorts.push_back(nocPkg::portT'(cur));
        expEnd.push_back(done);
      end
    end
  endtask

  task automatic driveRow(input int ph);
    int maxCount;
    maxCount = 0;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
      if (COUNT_TAB[ph][p] > maxCount)
        maxCount = COUNT_TAB[ph][p];
    for (int k = 0; k < maxCount; k++)
    begin
      @(negedge clk);
      for (int p = 0; p < nocPkg::NUM_PORTS; p++)
      begin
        inWrite[p] = (k < COUNT_TAB[ph][p]);
        if (k < COUNT_TAB[ph][p])
          inFlit[p] = phaseFlits[p][k];
      end
    end
    @(negedge clk);
    inWrite = '0;
  endtask

  task automatic checkFlit(input string name, input nocPkg::flitT exp, input nocPkg::flitT act);
    if (act !== exp)
    begin
      $display("mismatch at %0t: %s expected %h actual %h", $time, name, exp, act);
      flitErrors++;
    end
  endtask

  task automatic checkPort(input string name, input nocPkg::portT exp, input nocPkg::portT act);
    if (act !== exp)
    begin
      $display("mismatch at %0t: %s expected %0d actual %0d", $time, name, exp, act);
      portErrors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk)
    if (!rst)
      for (int p = 0; p < nocPkg::NUM_PORTS; p++)
        if (inWrite[p])
          writeCnt[p]++;

  always @(negedge clk)
  begin
    int occ;
    if (!rst)
    begin
      if (outValid)
      begin
        if (expPorts.size() == 0)
        begin
          $display("Error at %0t: output flit while no flit was expected", $time);
          otherErrors++;
        end
        else
        begin
          checkPort("outPort", expPorts.pop_front(), outPort);
          prevEnd = expEnd.pop_front();
        end
        if (outPort < 5 && portQ[outPort].size() > 0)
        begin
          checkFlit("outFlit", portQ[outPort].pop_front(), outFlit);
          popCnt[outPort]++;
        end
        else
        begin
          $display("Error at %0t: output flit from a port with nothing pending", $time);
          otherErrors++;
        end
      end
      else if (expPorts.size() > 0 && !prevEnd)
      begin
        $display("Error at %0t: gap in the output inside a grant", $time);
        otherErrors++;
      end
      for (int p = 0; p < nocPkg::NUM_PORTS; p++)
      begin
        occ = writeCnt[p] - popCnt[p];
        if (bufferFull[p] !== (occ >= DEPTH))
        begin
          $display("Error at %0t: bufferFull[%0d] is %b with %0d flits held",
                   $time, p, bufferFull[p], occ);
          otherErrors++;
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence, watchdog
  ////////////////////////////////////////////////////////////////////////////

  initial
  begin
    rst     = 1'b1;
    inWrite = '0;
    lfsr    = 32'h4686;
    prevEnd = 1'b1;
    flitErrors  = 0;
    portErrors  = 0;
    otherErrors = 0;
    for (int p = 0; p < nocPkg::NUM_PORTS; p++)
    begin
      inFlit[p]     = '0;
      quotaModel[p] = 1; // Stored quota after reset
      writeCnt[p]   = 0;
      popCnt[p]     = 0;
    end
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (outValid !== 1'b0 || bufferFull !== '0)
    begin
      $display("Error at %0t: outputs not idle after reset", $time);
      otherErrors++;
    end
    for (int ph = 0; ph < NUM_PHASES; ph++)
    begin
      buildPhase(ph);
      planTurns(ph);
      driveRow(ph);
      while (expPorts.size() > 0)
        @(posedge clk);
      repeat (4) @(posedge clk); // outValid must stay low here
      for (int p = 0; p < nocPkg::NUM_PORTS; p++)
        if (portQ[p].size() != 0)
        begin
          $display("Error: port %0d still holds %0d flits after phase %0d",
                   p, portQ[p].size(), ph);
          otherErrors++;
        end
    end
    $display("Errors: flit %0d, port %0d, other %0d", flitErrors, portErrors, otherErrors);
    if (flitErrors + portErrors + otherErrors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

  initial
  begin
    int total;
    total = 0;
    for (int ph = 0; ph < NUM_PHASES; ph++)
      for (int p = 0; p < nocPkg::NUM_PORTS; p++)
        total += COUNT_TAB[ph][p];
    repeat (40 * total + 100) @(posedge clk);
    $display("Timeout: the output link did not drain within %0d cycles", 40 * total + 100);
    $display("Simulation FAILED");
    $finish;
  end

endmodule

// ==== verilog.f ====
logic/nocPkg.sv
logic/inputBuffer.sv
logic/grantTimer.sv
logic/outputArbiter.sv
logic/routerOutputStage.sv
testbench/routerOutputStage_asserts.sv
testbench/routerOutputStageTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= routerOutputStageTb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation PASSED$$"

clean:
	rm -rf $(BUILD_DIR)
